// ==== src/core_consts.svh ====
// core widths and encodings
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define XLEN 64

`define OPC_SYSTEM 7'h73

`define F3_PRIV   3'd0
`define F3_CSRRW  3'd1
`define F3_CSRRS  3'd2
`define F3_CSRRC  3'd3
`define F3_ILLEGAL 3'd4
`define F3_CSRRWI 3'd5
`define F3_CSRRSI 3'd6
`define F3_CSRRCI 3'd7

// csr write kinds, low two bits of funct3
`define CSR_OP_NONE  2'd0
`define CSR_OP_WRITE 2'd1
`define CSR_OP_SET   2'd2
`define CSR_OP_CLEAR 2'd3

`define CSR_MSTATUS  12'h300
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343

`define CAUSE_FETCH_FAULT 64'd1
`define CAUSE_ILLEGAL     64'd2
`define CAUSE_BREAKPOINT  64'd3
`define CAUSE_LOAD_FAULT  64'd5
`define CAUSE_ECALL_M     64'd11

`define MSTATUS_RESET 64'h1800
`define MSTATUS_WMASK 64'h88
`define MSTATUS_MIE   3
`define MSTATUS_MPIE  7
`define MTVEC_RESET   64'h0

`endif

// ==== src/riscv_pkg.sv ====
// instruction word views
package riscv_pkg;

  // one 32-bit word seen as I-type or R-type
  typedef union packed {
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i_view;
    // system words with funct3 0 are told apart by funct7/rs2
    struct packed {
      logic [6:0]  funct7;
      logic [4:0]  rs2;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } r_view;
  } inst_u;

endpackage

// ==== src/csr_file.sv ====
// machine mode csr registers
`include "core_consts.svh"

module csr_file (
  input  logic              clock,
  input  logic              reset,
  input  logic [11:0]       csr_addr,
  output logic [`XLEN-1:0]  csr_rdata,
  output logic              csr_valid_addr,
  input  logic              csr_wen,
  input  logic [`XLEN-1:0]  csr_wdata,
  input  logic              trap_enter,
  input  logic [`XLEN-1:0]  trap_cause,
  input  logic [`XLEN-1:0]  trap_tval,
  input  logic [`XLEN-1:0]  trap_pc,
  input  logic              mret_enter,
  output logic [`XLEN-1:0]  mtvec,
  output logic [`XLEN-1:0]  mepc
);

  logic [`XLEN-1:0] mstatus;
  logic [`XLEN-1:0] mscratch;
  logic [`XLEN-1:0] mcause;
  logic [`XLEN-1:0] mtval;

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus  <= `MSTATUS_RESET;
      mtvec    <= `MTVEC_RESET;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else if (trap_enter) begin
      mepc    <= {trap_pc[`XLEN-1:2], 2'b00};
      mcause  <= trap_cause;
      mtval   <= trap_tval;
      mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];
      mstatus[`MSTATUS_MIE]  <= 1'b0;
    end else if (mret_enter) begin
      mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];
      mstatus[`MSTATUS_MPIE] <= 1'b1;
    end else if (csr_wen) begin
      case (csr_addr)
        // only MIE and MPIE change, MPP stays 11
        `CSR_MSTATUS:
          mstatus <= (mstatus & ~`MSTATUS_WMASK) | (csr_wdata & `MSTATUS_WMASK);
        `CSR_MTVEC:    mtvec    <= {csr_wdata[`XLEN-1:2], 2'b00};
        `CSR_MSCRATCH: mscratch <= csr_wdata;
        `CSR_MEPC:     mepc     <= {csr_wdata[`XLEN-1:2], 2'b00};
        `CSR_MCAUSE:   mcause   <= csr_wdata;
        `CSR_MTVAL:    mtval    <= csr_wdata;
        default: ;
      endcase
    end
  end

  // read mux, unknown addresses flag illegal
  always_comb begin
    csr_rdata      = '0;
    csr_valid_addr = 1'b1;
    case (csr_addr)
      `CSR_MSTATUS:  csr_rdata = mstatus;
      `CSR_MTVEC:    csr_rdata = mtvec;
      `CSR_MSCRATCH: csr_rdata = mscratch;
      `CSR_MEPC:     csr_rdata = mepc;
      `CSR_MCAUSE:   csr_rdata = mcause;
      `CSR_MTVAL:    csr_rdata = mtval;
      default:       csr_valid_addr = 1'b0;
    endcase
  end

endmodule

// ==== src/trap_detect.sv ====
// retire trap and csr decode
`include "core_consts.svh"

module trap_detect import riscv_pkg::*; (
  input  logic [`XLEN-1:0]  retire_pc,
  input  inst_u             retire_inst,
  input  logic [`XLEN-1:0]  retire_rs1_data,
  input  logic              retire_fetch_fault,
  input  logic              retire_mem_fault,
  input  logic [`XLEN-1:0]  retire_fault_addr,
  input  logic              csr_valid_addr,
  output logic              take_trap,
  output logic [`XLEN-1:0]  trap_cause,
  output logic [`XLEN-1:0]  trap_tval,
  output logic              is_mret,
  output logic              csr_access,
  output logic [1:0]        csr_write_kind,
  output logic [`XLEN-1:0]  csr_operand
);

  logic       is_system;
  logic       is_priv;
  logic       is_csr;
  logic       priv_zero_regs;
  logic       ecall_w;
  logic       ebreak_w;
  logic       mret_w;
  logic       illegal;
  logic [2:0] f3;

  assign f3        = retire_inst.i_view.funct3;
  assign is_system = retire_inst.i_view.opcode == `OPC_SYSTEM;
  assign is_priv   = is_system && f3 == `F3_PRIV;
  assign is_csr    = is_system && f3 != `F3_PRIV && f3 != `F3_ILLEGAL;

  // privileged words need rd = rs1 = 0
  assign priv_zero_regs = retire_inst.r_view.rs1 == 5'd0 && retire_inst.r_view.rd == 5'd0;

  assign ecall_w  = is_priv && priv_zero_regs && retire_inst.r_view.funct7 == 7'd0 &&
                    retire_inst.r_view.rs2 == 5'd0;
  assign ebreak_w = is_priv && priv_zero_regs && retire_inst.r_view.funct7 == 7'd0 &&
                    retire_inst.r_view.rs2 == 5'd1;
  assign mret_w   = is_priv && priv_zero_regs && retire_inst.r_view.funct7 == 7'b0011000 &&
                    retire_inst.r_view.rs2 == 5'b00010;

  assign illegal = (is_system && f3 == `F3_ILLEGAL) ||
                   (is_priv && !(ecall_w || ebreak_w || mret_w)) ||
                   (is_csr && !csr_valid_addr);

  assign take_trap = retire_fetch_fault || illegal || ebreak_w || ecall_w || retire_mem_fault;

  // priority: fetch, illegal, ebreak, ecall, memory
  always_comb begin
    trap_cause = '0;
    trap_tval  = '0;
    if (retire_fetch_fault) begin
      trap_cause = `CAUSE_FETCH_FAULT;
      trap_tval  = retire_pc;
    end else if (illegal) begin
      trap_cause = `CAUSE_ILLEGAL;
      trap_tval  = {{(`XLEN-32){1'b0}}, retire_inst};
    end else if (ebreak_w) begin
      trap_cause = `CAUSE_BREAKPOINT;
      trap_tval  = retire_pc;
    end else if (ecall_w) begin
      trap_cause = `CAUSE_ECALL_M;
    end else if (retire_mem_fault) begin
      trap_cause = `CAUSE_LOAD_FAULT;
      trap_tval  = retire_fault_addr;
    end
  end

  assign is_mret    = mret_w && !take_trap;
  assign csr_access = is_csr && !take_trap;

  // set/clear with rs1 field 0 is a pure read
  always_comb begin
    csr_write_kind = f3[1:0];
    if (f3[1] && retire_inst.i_view.rs1 == 5'd0)
      csr_write_kind = `CSR_OP_NONE;
  end

  // immediate forms use the zero-extended rs1 field
  assign csr_operand = f3[2] ? {{(`XLEN-5){1'b0}}, retire_inst.i_view.rs1} : retire_rs1_data;

endmodule

// ==== src/commit_unit.sv ====
// commit record and update control
`include "core_consts.svh"

module commit_unit import riscv_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic              retire_valid,
  input  logic [`XLEN-1:0]  retire_pc,
  input  inst_u             retire_inst,
  output logic              retire_allowin,
  input  logic              take_trap,
  input  logic [`XLEN-1:0]  trap_cause,
  input  logic              is_mret,
  input  logic              csr_access,
  input  logic [1:0]        csr_write_kind,
  input  logic [`XLEN-1:0]  csr_operand,
  input  logic [`XLEN-1:0]  csr_rdata,
  input  logic [`XLEN-1:0]  mtvec,
  input  logic [`XLEN-1:0]  mepc,
  output logic              csr_wen,
  output logic [`XLEN-1:0]  csr_wdata,
  output logic              trap_enter,
  output logic              mret_enter,
  output logic              commit_valid,
  output logic [`XLEN-1:0]  commit_pc,
  output inst_u             commit_inst,
  output logic              commit_wen,
  output logic [7:0]        commit_wdest,
  output logic [`XLEN-1:0]  commit_wdata,
  output logic              commit_trap,
  output logic [`XLEN-1:0]  commit_cause,
  output logic              redirect_valid,
  output logic [`XLEN-1:0]  redirect_pc,
  output logic [63:0]       cycle_count,
  output logic [63:0]       instr_count,
  input  logic              commit_ready
);

  logic accept;
  logic commit_fire;

  assign retire_allowin = !commit_valid || commit_ready;
  assign accept         = retire_valid && retire_allowin;
  assign commit_fire    = commit_valid && commit_ready;

  always_comb begin
    case (csr_write_kind)
      `CSR_OP_WRITE: csr_wdata = csr_operand;
      `CSR_OP_SET:   csr_wdata = csr_rdata | csr_operand;
      `CSR_OP_CLEAR: csr_wdata = csr_rdata & ~csr_operand;
      default:       csr_wdata = csr_rdata;
    endcase
  end

  // all architectural updates land on the accept edge
  assign csr_wen    = accept && csr_access && csr_write_kind != `CSR_OP_NONE;
  assign trap_enter = accept && take_trap;
  assign mret_enter = accept && is_mret;

  always_ff @(posedge clock) begin
    if (reset) begin
      commit_valid   <= 1'b0;
      redirect_valid <= 1'b0;
    end else if (accept) begin
      commit_valid   <= 1'b1;
      redirect_valid <= take_trap || is_mret;
    end else if (commit_ready) begin
      commit_valid   <= 1'b0;
      redirect_valid <= 1'b0;
    end
  end

  // payload, qualified by commit_valid
  always_ff @(posedge clock) begin
    if (accept) begin
      commit_pc    <= retire_pc;
      commit_inst  <= retire_inst;
      commit_wen   <= csr_access && retire_inst.i_view.rd != 5'd0;
      commit_wdest <= {3'b000, retire_inst.i_view.rd};
      commit_wdata <= csr_access ? csr_rdata : '0;
      commit_trap  <= take_trap;
      commit_cause <= take_trap ? trap_cause : '0;
      redirect_pc  <= take_trap ? mtvec : mepc;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      cycle_count <= '0;
      instr_count <= '0;
    end else begin
      cycle_count <= cycle_count + 64'd1;
      if (commit_fire)
        instr_count <= instr_count + 64'd1;
    end
  end

endmodule

// ==== src/trap_top.sv ====
// trap and csr subsystem top
`include "core_consts.svh"

module trap_top import riscv_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic              retire_valid,
  input  logic [`XLEN-1:0]  retire_pc,
  input  inst_u             retire_inst,
  input  logic [`XLEN-1:0]  retire_rs1_data,
  input  logic              retire_fetch_fault,
  input  logic              retire_mem_fault,
  input  logic [`XLEN-1:0]  retire_fault_addr,
  output logic              retire_allowin,
  output logic              commit_valid,
  output logic [`XLEN-1:0]  commit_pc,
  output inst_u             commit_inst,
  output logic              commit_wen,
  output logic [7:0]        commit_wdest,
  output logic [`XLEN-1:0]  commit_wdata,
  output logic              commit_trap,
  output logic [`XLEN-1:0]  commit_cause,
  output logic              redirect_valid,
  output logic [`XLEN-1:0]  redirect_pc,
  output logic [63:0]       cycle_count,
  output logic [63:0]       instr_count,
  input  logic              commit_ready
);

  logic             take_trap;
  logic [`XLEN-1:0] trap_cause;
  logic [`XLEN-1:0] trap_tval;
  logic             is_mret;
  logic             csr_access;
  logic [1:0]       csr_write_kind;
  logic [`XLEN-1:0] csr_operand;
  logic [`XLEN-1:0] csr_rdata;
  logic             csr_valid_addr;
  logic             csr_wen;
  logic [`XLEN-1:0] csr_wdata;
  logic             trap_enter;
  logic             mret_enter;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;

  csr_file u_csr_file (
    .clock          (clock),
    .reset          (reset),
    .csr_addr       (retire_inst.i_view.imm12),
    .csr_rdata      (csr_rdata),
    .csr_valid_addr (csr_valid_addr),
    .csr_wen        (csr_wen),
    .csr_wdata      (csr_wdata),
    .trap_enter     (trap_enter),
    .trap_cause     (trap_cause),
    .trap_tval      (trap_tval),
    .trap_pc        (retire_pc),
    .mret_enter     (mret_enter),
    .mtvec          (mtvec),
    .mepc           (mepc)
  );

  trap_detect u_trap_detect (
    .retire_pc          (retire_pc),
    .retire_inst        (retire_inst),
    .retire_rs1_data    (retire_rs1_data),
    .retire_fetch_fault (retire_fetch_fault),
    .retire_mem_fault   (retire_mem_fault),
    .retire_fault_addr  (retire_fault_addr),
    .csr_valid_addr     (csr_valid_addr),
    .take_trap          (take_trap),
    .trap_cause         (trap_cause),
    .trap_tval          (trap_tval),
    .is_mret            (is_mret),
    .csr_access         (csr_access),
    .csr_write_kind     (csr_write_kind),
    .csr_operand        (csr_operand)
  );

  commit_unit u_commit_unit (
    .clock          (clock),
    .reset          (reset),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_inst    (retire_inst),
    .retire_allowin (retire_allowin),
    .take_trap      (take_trap),
    .trap_cause     (trap_cause),
    .is_mret        (is_mret),
    .csr_access     (csr_access),
    .csr_write_kind (csr_write_kind),
    .csr_operand    (csr_operand),
    .csr_rdata      (csr_rdata),
    .mtvec          (mtvec),
    .mepc           (mepc),
    .csr_wen        (csr_wen),
    .csr_wdata      (csr_wdata),
    .trap_enter     (trap_enter),
    .mret_enter     (mret_enter),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_inst    (commit_inst),
    .commit_wen     (commit_wen),
    .commit_wdest   (commit_wdest),
    .commit_wdata   (commit_wdata),
    .commit_trap    (commit_trap),
    .commit_cause   (commit_cause),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .cycle_count    (cycle_count),
    .instr_count    (instr_count),
    .commit_ready   (commit_ready)
  );

endmodule

// ==== tests/trap_tb.sv ====
// trap and csr testbench
`include "core_consts.svh"

module trap_tb import riscv_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 50;

  logic        clock;
  logic        reset;
  logic        retire_valid;
  logic [63:0] retire_pc;
  inst_u       retire_inst;
  logic [63:0] retire_rs1_data;
  logic        retire_fetch_fault;
  logic        retire_mem_fault;
  logic [63:0] retire_fault_addr;
  logic        retire_allowin;
  logic        commit_valid;
  logic [63:0] commit_pc;
  inst_u       commit_inst;
  logic        commit_wen;
  logic [7:0]  commit_wdest;
  logic [63:0] commit_wdata;
  logic        commit_trap;
  logic [63:0] commit_cause;
  logic        redirect_valid;
  logic [63:0] redirect_pc;
  logic [63:0] cycle_count;
  logic [63:0] instr_count;
  logic        commit_ready;

  // reference model of the csr state
  logic [63:0] m_mstatus;
  logic [63:0] m_mtvec;
  logic [63:0] m_mscratch;
  logic [63:0] m_mepc;
  logic [63:0] m_mcause;
  logic [63:0] m_mtval;

  logic [31:0] lcg_state;
  logic [63:0] next_pc;
  logic [63:0] handshakes;
  logic [63:0] cycles_run;

  trap_top uut (.*);

  always #10 clock = ~clock;

  // rising edges seen with reset low
  always @(posedge clock) begin
    if (!reset)
      cycles_run = cycles_run + 64'd1;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [63:0] rand_word();
    return {lcg_next(), lcg_next()};
  endfunction

  function automatic inst_u make_i(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd);
    inst_u w;
    w.i_view.imm12  = imm;
    w.i_view.rs1    = rs1;
    w.i_view.funct3 = f3;
    w.i_view.rd     = rd;
    w.i_view.opcode = `OPC_SYSTEM;
    return w;
  endfunction

  // ecall, ebreak and mret differ only in funct7 and rs2
  function automatic inst_u make_priv(input logic [6:0] funct7, input logic [4:0] rs2);
    inst_u w;
    w.r_view.funct7 = funct7;
    w.r_view.rs2    = rs2;
    w.r_view.rs1    = 5'd0;
    w.r_view.funct3 = `F3_PRIV;
    w.r_view.rd     = 5'd0;
    w.r_view.opcode = `OPC_SYSTEM;
    return w;
  endfunction

  function automatic logic [63:0] model_read(input logic [11:0] addr);
    case (addr)
      `CSR_MSTATUS:  return m_mstatus;
      `CSR_MTVEC:    return m_mtvec;
      `CSR_MSCRATCH: return m_mscratch;
      `CSR_MEPC:     return m_mepc;
      `CSR_MCAUSE:   return m_mcause;
      `CSR_MTVAL:    return m_mtval;
      default:       return 64'd0;
    endcase
  endfunction

  task automatic model_write(input logic [11:0] addr, input logic [63:0] v);
    case (addr)
      // MIE and MPIE only
      `CSR_MSTATUS:  m_mstatus = (m_mstatus & ~64'h88) | (v & 64'h88);
      `CSR_MTVEC:    m_mtvec = v & ~64'h3;
      `CSR_MSCRATCH: m_mscratch = v;
      `CSR_MEPC:     m_mepc = v & ~64'h3;
      `CSR_MCAUSE:   m_mcause = v;
      `CSR_MTVAL:    m_mtval = v;
      default: ;
    endcase
  endtask

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
      stop_with_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_with_error($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                $time, name, got, exp));
  endtask

  task automatic check_inst(input string name, input inst_u got, input inst_u exp);
    if (got !== exp)
      stop_with_error($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                $time, name, got, exp));
  endtask

  // one retire handshake up to the commit record
  task automatic retire_one(input inst_u inst, input logic [63:0] rs1_data,
                            input logic fetch_fault, input logic mem_fault,
                            input logic [63:0] fault_addr);
    int n;
    @(posedge clock);
    #2;
    retire_valid       = 1'b1;
    retire_pc          = next_pc;
    retire_inst        = inst;
    retire_rs1_data    = rs1_data;
    retire_fetch_fault = fetch_fault;
    retire_mem_fault   = mem_fault;
    retire_fault_addr  = fault_addr;
    n = 0;
    @(negedge clock);
    while (!retire_allowin) begin
      n++;
      if (n > WAIT_LIMIT)
        stop_with_error("timeout: retire_allowin stayed low");
      @(negedge clock);
    end
    @(posedge clock);
    #2;
    retire_valid = 1'b0;
    handshakes = handshakes + 64'd1;
    n = 0;
    while (!commit_valid) begin
      n++;
      if (n > WAIT_LIMIT)
        stop_with_error("timeout: commit_valid never rose");
      @(negedge clock);
    end
    check_word("commit_pc", commit_pc, next_pc);
    check_inst("commit_inst", commit_inst, inst);
    next_pc = next_pc + 64'd4;
  endtask

  task automatic csr_op(input logic [2:0] f3, input logic [11:0] addr,
                        input logic [4:0] rs1_field, input logic [4:0] rd,
                        input logic [63:0] rs1_data);
    logic [63:0] old;
    logic [63:0] operand;
    old = model_read(addr);
    operand = f3[2] ? {59'd0, rs1_field} : rs1_data;
    retire_one(make_i(addr, rs1_field, f3, rd), rs1_data, 1'b0, 1'b0, 64'd0);
    check_bit("commit_trap", commit_trap, 1'b0);
    check_bit("redirect_valid", redirect_valid, 1'b0);
    check_bit("commit_wen", commit_wen, rd != 5'd0);
    check_word("commit_wdest", {56'd0, commit_wdest}, {59'd0, rd});
    check_word("commit_wdata", commit_wdata, old);
    case (f3[1:0])
      2'd1: model_write(addr, operand);
      2'd2: if (rs1_field != 5'd0) model_write(addr, old | operand);
      2'd3: if (rs1_field != 5'd0) model_write(addr, old & ~operand);
      default: ;
    endcase
  endtask

  // csrrs with x0 reads without writing
  task automatic read_back(input logic [11:0] addr);
    csr_op(`F3_CSRRS, addr, 5'd0, 5'd10, rand_word());
  endtask

  task automatic expect_trap(input inst_u inst, input logic fetch_fault, input logic mem_fault,
                             input logic [63:0] fault_addr, input logic [63:0] cause,
                             input logic [63:0] tval);
    logic [63:0] pc;
    pc = next_pc;
    retire_one(inst, rand_word(), fetch_fault, mem_fault, fault_addr);
    check_bit("commit_trap", commit_trap, 1'b1);
    check_word("commit_cause", commit_cause, cause);
    check_bit("commit_wen", commit_wen, 1'b0);
    check_bit("redirect_valid", redirect_valid, 1'b1);
    check_word("redirect_pc", redirect_pc, m_mtvec);
    m_mepc = pc;
    m_mcause = cause;
    m_mtval = tval;
    m_mstatus[7] = m_mstatus[3];
    m_mstatus[3] = 1'b0;
    read_back(`CSR_MEPC);
    read_back(`CSR_MCAUSE);
    read_back(`CSR_MTVAL);
    read_back(`CSR_MSTATUS);
  endtask

  task automatic expect_mret();
    retire_one(make_priv(7'b0011000, 5'b00010), 64'd0, 1'b0, 1'b0, 64'd0);
    check_bit("commit_trap", commit_trap, 1'b0);
    check_word("commit_cause", commit_cause, 64'd0);
    check_bit("commit_wen", commit_wen, 1'b0);
    check_bit("redirect_valid", redirect_valid, 1'b1);
    check_word("redirect_pc", redirect_pc, m_mepc);
    m_mstatus[3] = m_mstatus[7];
    m_mstatus[7] = 1'b1;
    read_back(`CSR_MSTATUS);
  endtask

  task automatic test_after_reset();
    check_bit("commit_valid", commit_valid, 1'b0);
    check_bit("redirect_valid", redirect_valid, 1'b0);
    check_bit("retire_allowin", retire_allowin, 1'b1);
    check_word("instr_count", instr_count, 64'd0);
    check_word("cycle_count", cycle_count, 64'd0);
    read_back(`CSR_MSTATUS);
    check_word("mstatus", commit_wdata, 64'h1800);
  endtask

  task automatic test_csr_access();
    csr_op(`F3_CSRRW, `CSR_MSCRATCH, 5'd3, 5'd1, rand_word());
    read_back(`CSR_MSCRATCH);
    csr_op(`F3_CSRRS, `CSR_MSCRATCH, 5'd4, 5'd2, rand_word());
    csr_op(`F3_CSRRC, `CSR_MSCRATCH, 5'd5, 5'd0, rand_word());
    read_back(`CSR_MSCRATCH);
    csr_op(`F3_CSRRS, `CSR_MSCRATCH, 5'd0, 5'd7, 64'hffff_ffff_ffff_ffff);
    csr_op(`F3_CSRRC, `CSR_MSCRATCH, 5'd0, 5'd7, 64'hffff_ffff_ffff_ffff);
    read_back(`CSR_MSCRATCH);
    csr_op(`F3_CSRRWI, `CSR_MTVEC, 5'h17, 5'd8, 64'd0);
    read_back(`CSR_MTVEC);
    csr_op(`F3_CSRRW, `CSR_MTVEC, 5'd9, 5'd8, rand_word());
    csr_op(`F3_CSRRSI, `CSR_MTVEC, 5'd0, 5'd8, 64'd0);
    read_back(`CSR_MTVEC);
    csr_op(`F3_CSRRCI, `CSR_MSCRATCH, 5'h1f, 5'd11, 64'd0);
    csr_op(`F3_CSRRSI, `CSR_MSCRATCH, 5'h0a, 5'd11, 64'd0);
    read_back(`CSR_MSCRATCH);
    // MPP must survive an all-ones write
    csr_op(`F3_CSRRW, `CSR_MSTATUS, 5'd1, 5'd3, 64'hffff_ffff_ffff_ffff);
    read_back(`CSR_MSTATUS);
  endtask

  task automatic test_traps();
    inst_u w;
    expect_trap(make_priv(7'd0, 5'd0), 1'b0, 1'b0, 64'd0, `CAUSE_ECALL_M, 64'd0);
    expect_trap(make_priv(7'd0, 5'd1), 1'b0, 1'b0, 64'd0, `CAUSE_BREAKPOINT, next_pc);
    w = 32'h0000_0013;
    expect_trap(w, 1'b0, 1'b1, 64'h0000_1230, `CAUSE_LOAD_FAULT, 64'h0000_1230);
    // priority cases
    expect_trap(w, 1'b1, 1'b1, 64'h0000_4560, `CAUSE_FETCH_FAULT, next_pc);
    w = make_i(12'h000, 5'd0, 3'd4, 5'd0);
    expect_trap(w, 1'b0, 1'b0, 64'd0, `CAUSE_ILLEGAL, {32'd0, w});
    w = make_i(12'h7c0, 5'd1, `F3_CSRRW, 5'd2);
    expect_trap(w, 1'b0, 1'b1, 64'h0000_0040, `CAUSE_ILLEGAL, {32'd0, w});
    expect_trap(w, 1'b1, 1'b0, 64'd0, `CAUSE_FETCH_FAULT, next_pc);
    // plain opcode has no effect
    retire_one(32'h0000_0013, 64'd0, 1'b0, 1'b0, 64'd0);
    check_bit("commit_trap", commit_trap, 1'b0);
    check_bit("redirect_valid", redirect_valid, 1'b0);
    check_bit("commit_wen", commit_wen, 1'b0);
  endtask

  task automatic test_mret();
    csr_op(`F3_CSRRC, `CSR_MSTATUS, 5'd2, 5'd0, 64'h88);
    csr_op(`F3_CSRRS, `CSR_MSTATUS, 5'd2, 5'd0, 64'h80);
    expect_mret();
    csr_op(`F3_CSRRC, `CSR_MSTATUS, 5'd2, 5'd0, 64'h80);
    expect_mret();
  endtask

  task automatic test_backpressure();
    logic [63:0] held_pc;
    logic [63:0] held_data;
    inst_u       held_inst;
    logic [63:0] v;
    int n;
    @(posedge clock);
    #2;
    commit_ready = 1'b0;
    csr_op(`F3_CSRRW, `CSR_MSCRATCH, 5'd6, 5'd4, rand_word());
    held_pc = commit_pc;
    held_data = commit_wdata;
    held_inst = commit_inst;
    // second instruction waits behind the stalled commit
    v = rand_word();
    @(posedge clock);
    #2;
    retire_valid    = 1'b1;
    retire_pc       = next_pc;
    retire_inst     = make_i(`CSR_MSCRATCH, 5'd6, `F3_CSRRW, 5'd5);
    retire_rs1_data = v;
    repeat (4) begin
      @(negedge clock);
      check_bit("commit_valid", commit_valid, 1'b1);
      check_word("commit_pc", commit_pc, held_pc);
      check_inst("commit_inst", commit_inst, held_inst);
      check_word("commit_wdata", commit_wdata, held_data);
      check_bit("retire_allowin", retire_allowin, 1'b0);
    end
    @(posedge clock);
    #2;
    commit_ready = 1'b1;
    n = 0;
    @(negedge clock);
    while (!retire_allowin) begin
      n++;
      if (n > WAIT_LIMIT)
        stop_with_error("timeout: retire_allowin stayed low after release");
      @(negedge clock);
    end
    @(posedge clock);
    #2;
    retire_valid = 1'b0;
    handshakes = handshakes + 64'd1;
    check_bit("commit_valid", commit_valid, 1'b1);
    check_word("commit_pc", commit_pc, next_pc);
    check_word("commit_wdata", commit_wdata, m_mscratch);
    model_write(`CSR_MSCRATCH, v);
    next_pc = next_pc + 64'd4;
    @(posedge clock);
    #2;
    check_bit("commit_valid", commit_valid, 1'b0);
    check_word("instr_count", instr_count, handshakes);
    check_word("cycle_count", cycle_count, cycles_run);
    read_back(`CSR_MSCRATCH);
  endtask

  initial begin
    clock              = 1'b0;
    reset              = 1'b1;
    retire_valid       = 1'b0;
    retire_pc          = 64'd0;
    retire_inst        = 32'd0;
    retire_rs1_data    = 64'd0;
    retire_fetch_fault = 1'b0;
    retire_mem_fault   = 1'b0;
    retire_fault_addr  = 64'd0;
    commit_ready       = 1'b1;
    lcg_state          = 32'd50;
    next_pc            = 64'h0000_0000_8000_0000;
    handshakes         = 64'd0;
    cycles_run         = 64'd0;
    m_mstatus          = 64'h1800;
    m_mtvec            = 64'd0;
    m_mscratch         = 64'd0;
    m_mepc             = 64'd0;
    m_mcause           = 64'd0;
    m_mtval            = 64'd0;
    repeat (5) @(posedge clock);
    #2;
    reset = 1'b0;
    test_after_reset();
    test_csr_access();
    test_traps();
    test_mret();
    test_backpressure();
    $display("No errors");
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+src
src/riscv_pkg.sv
src/csr_file.sv
src/trap_detect.sv
src/commit_unit.sv
src/trap_top.sv
tests/trap_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= trap_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_TEXT ?= No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
